//--- rtl/pixel_pkg.sv
package pixel_pkg;

    // One colour channel of a pixel
    typedef logic [7:0] pixel_t;

    // Channel value times a channel mean, never above 255 * 255
    typedef logic [15:0] product_t;

    // Cb weights, scaled by 256
    localparam int CB_R = 38;
    localparam int CB_G = 74;
    localparam int CB_B = 112;

    // Cr weights, scaled by 256
    localparam int CR_R = 112;
    localparam int CR_G = 94;
    localparam int CR_B = 18;

    // Both chroma components are centred on this value
    localparam int CHROMA_OFFSET = 128;

    // Skin window in the Cb/Cr plane, inclusive
    localparam int CB_MIN = 90;
    localparam int CB_MAX = 120;
    localparam int CR_MIN = 139;
    localparam int CR_MAX = 170;

    // Mask pixel values written on all three channels
    localparam pixel_t MASK_ON = 8'd255;
    localparam pixel_t MASK_OFF = 8'd0;

endpackage

//--- rtl/phase_pkg.sv
package phase_pkg;

    // Pass that the pixel on the read data ports belongs to.
    // MEAN is the gap between accumulation and compensation
    typedef enum logic [2:0] {
        IDLE,
        ACCUM,
        MEAN,
        COMP,
        CHROMA,
        MEASURE
    } phase_t;

endpackage

//--- rtl/channel_mean.sv
module channel_mean
    import pixel_pkg::*;
    import phase_pkg::*;
#(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 240,
    localparam int PIXELS = FRAME_W * FRAME_H,
    localparam int ADDR_W = $clog2(PIXELS + 1)
) (
    input  logic   clk,
    input  logic   rst,
    input  phase_t phase,
    input  logic   pass_first,
    input  logic   pass_last,
    input  pixel_t rd_red,
    input  pixel_t rd_green,
    input  pixel_t rd_blue,
    output pixel_t red_mean,
    output pixel_t green_mean,
    output pixel_t blue_mean,
    output pixel_t max_mean
);

    // Wide enough for 255 on every pixel of the frame
    localparam int SUM_W = ADDR_W + 8;

    logic [SUM_W-1:0] red_acc;
    logic [SUM_W-1:0] green_acc;
    logic [SUM_W-1:0] blue_acc;
    logic             mean_go;
    logic             max_go;

    // First pixel of the pass loads the sums directly
    always_ff @(posedge clk) begin
        if (phase == ACCUM) begin
            red_acc   <= (pass_first ? '0 : red_acc) + SUM_W'(rd_red);
            green_acc <= (pass_first ? '0 : green_acc) + SUM_W'(rd_green);
            blue_acc  <= (pass_first ? '0 : blue_acc) + SUM_W'(rd_blue);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mean_go    <= 1'b0;
            max_go     <= 1'b0;
            red_mean   <= '0;
            green_mean <= '0;
            blue_mean  <= '0;
            max_mean   <= '0;
        end
        else begin
            mean_go <= (phase == ACCUM) && pass_last;
            max_go  <= mean_go;
            // Sums are complete the cycle after the last pixel
            if (mean_go) begin
                red_mean   <= pixel_t'(red_acc / SUM_W'(PIXELS));
                green_mean <= pixel_t'(green_acc / SUM_W'(PIXELS));
                blue_mean  <= pixel_t'(blue_acc / SUM_W'(PIXELS));
            end
            if (max_go) begin
                if (red_mean >= green_mean && red_mean >= blue_mean) begin
                    max_mean <= red_mean;
                end
                else if (green_mean >= blue_mean) begin
                    max_mean <= green_mean;
                end
                else begin
                    max_mean <= blue_mean;
                end
            end
        end
    end

    // Only the cycle between new means and the new largest mean is exempt
    assert property (@(posedge clk) disable iff (!rst)
        !max_go |->
            (max_mean >= red_mean) && (max_mean >= green_mean) && (max_mean >= blue_mean))
        else $error("largest mean is below one of the channel means");

endmodule

//--- rtl/illum_comp.sv
module illum_comp
    import pixel_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  pixel_t rd_red,
    input  pixel_t rd_green,
    input  pixel_t rd_blue,
    input  pixel_t red_mean,
    input  pixel_t green_mean,
    input  pixel_t blue_mean,
    input  pixel_t max_mean,
    output pixel_t comp_red,
    output pixel_t comp_green,
    output pixel_t comp_blue
);

    product_t red_prod;
    product_t green_prod;
    product_t blue_prod;
    logic     max_zero;

    assign max_zero = (max_mean == '0);

    // Stage one, scale each channel by its own mean
    always_ff @(posedge clk) begin
        red_prod   <= product_t'(rd_red) * product_t'(red_mean);
        green_prod <= product_t'(rd_green) * product_t'(green_mean);
        blue_prod  <= product_t'(rd_blue) * product_t'(blue_mean);
    end

    // Stage two, normalise by the largest mean.
    // The means lead max_mean by one cycle, the same as this pipeline,
    // so every pixel sees a matching pair
    always_ff @(posedge clk) begin
        if (!rst) begin
            comp_red   <= '0;
            comp_green <= '0;
            comp_blue  <= '0;
        end
        else if (max_zero) begin
            comp_red   <= '0;
            comp_green <= '0;
            comp_blue  <= '0;
        end
        else begin
            comp_red   <= pixel_t'(red_prod / product_t'(max_mean));
            comp_green <= pixel_t'(green_prod / product_t'(max_mean));
            comp_blue  <= pixel_t'(blue_prod / product_t'(max_mean));
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        $past(rst, 2) |->
            (comp_red <= $past(rd_red, 2)) &&
            (comp_green <= $past(rd_green, 2)) &&
            (comp_blue <= $past(rd_blue, 2)))
        else $error("compensated channel above its input channel");

endmodule

//--- rtl/skin_classify.sv
module skin_classify
    import pixel_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  pixel_t rd_red,
    input  pixel_t rd_green,
    input  pixel_t rd_blue,
    output pixel_t mask_pixel
);

    int   cb_sum;
    int   cr_sum;
    int   cb;
    int   cr;
    logic in_window;

    always_comb begin
        // Weighted sums before the divide by 256
        cb_sum = CB_B * int'(rd_blue) - CB_R * int'(rd_red) - CB_G * int'(rd_green);
        cr_sum = CR_R * int'(rd_red) - CR_G * int'(rd_green) - CR_B * int'(rd_blue);

        // Arithmetic shift rounds toward minus infinity
        cb = CHROMA_OFFSET + (cb_sum >>> 8);
        cr = CHROMA_OFFSET + (cr_sum >>> 8);

        in_window = (cb >= CB_MIN) && (cb <= CB_MAX) &&
                    (cr >= CR_MIN) && (cr <= CR_MAX);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mask_pixel <= MASK_OFF;
        end
        else if (in_window) begin
            mask_pixel <= MASK_ON;
        end
        else begin
            mask_pixel <= MASK_OFF;
        end
    end

endmodule

//--- rtl/blob_measure.sv
module blob_measure
    import pixel_pkg::*;
    import phase_pkg::*;
#(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 240,
    localparam int PIXELS = FRAME_W * FRAME_H,
    localparam int ADDR_W = $clog2(PIXELS + 1)
) (
    input  logic              clk,
    input  logic              rst,
    input  phase_t            phase,
    input  logic              pass_first,
    input  pixel_t            rd_red,
    output logic [ADDR_W-1:0] area,
    output logic [ADDR_W-1:0] perimeter
);

    localparam logic [ADDR_W-1:0] MAX_COUNT = ADDR_W'(PIXELS);

    pixel_t            prev_pixel;
    pixel_t            prev_ref;
    logic [ADDR_W-1:0] area_base;
    logic [ADDR_W-1:0] perim_base;

    // First pixel of the frame is compared against zero
    assign prev_ref   = pass_first ? '0 : prev_pixel;
    assign area_base  = pass_first ? '0 : area;
    assign perim_base = pass_first ? '0 : perimeter;

    always_ff @(posedge clk) begin
        if (!rst) begin
            area      <= '0;
            perimeter <= '0;
        end
        else if (phase == MEASURE) begin
            area      <= area_base + ADDR_W'(rd_red == MASK_ON);
            perimeter <= perim_base + ADDR_W'(rd_red != prev_ref);
        end
    end

    // Row ends are not special, the walk is in address order
    always_ff @(posedge clk) begin
        if (phase == MEASURE) begin
            prev_pixel <= rd_red;
        end
    end

    assert property (@(posedge clk) disable iff (!rst) area <= MAX_COUNT)
        else $error("hand area larger than the frame");

endmodule

//--- rtl/frame_sequencer.sv
module frame_sequencer
    import phase_pkg::*;
#(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 240,
    localparam int PIXELS = FRAME_W * FRAME_H,
    localparam int ADDR_W = $clog2(PIXELS + 1)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output phase_t            phase,
    output logic              pass_first,
    output logic              pass_last,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              we,
    output logic [ADDR_W-1:0] wr_addr,
    output logic              done
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_ACCUM,
        S_MEAN,
        S_COMP,
        S_COMP_DRAIN,
        S_CHROMA,
        S_CHROMA_DRAIN,
        S_MEASURE,
        S_FINISH
    } state_t;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(PIXELS - 1);
    // Gap lengths are one more than the loaded count
    localparam logic [1:0] MEAN_GAP = 2'd3;
    localparam logic [1:0] DRAIN_GAP = 2'd1;

    state_t            state;
    phase_t            state_phase;
    logic              issue;
    logic [1:0]        gap_cnt;
    logic [2:0]        line_valid;
    logic [ADDR_W-1:0] line_addr [3];

    // Drain cycles keep the pass phase so late writes still select it
    always_comb begin
        case (state)
            S_ACCUM: state_phase = ACCUM;
            S_MEAN: state_phase = MEAN;
            S_COMP, S_COMP_DRAIN: state_phase = COMP;
            S_CHROMA, S_CHROMA_DRAIN: state_phase = CHROMA;
            S_MEASURE: state_phase = MEASURE;
            default: state_phase = IDLE;
        endcase
    end

    assign issue = state inside {S_ACCUM, S_COMP, S_CHROMA, S_MEASURE};

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= S_IDLE;
            rd_addr <= '0;
            gap_cnt <= '0;
            done    <= 1'b0;
        end
        else begin
            case (state)
                S_IDLE: begin
                    rd_addr <= '0;
                    if (start && !done) begin
                        state <= S_ACCUM;
                    end
                    else if (!start) begin
                        done <= 1'b0;
                    end
                end
                S_ACCUM, S_COMP, S_CHROMA, S_MEASURE: begin
                    rd_addr <= rd_addr + 1'b1;
                    if (rd_addr == LAST_ADDR) begin
                        rd_addr <= '0;
                        gap_cnt <= (state == S_ACCUM) ? MEAN_GAP : DRAIN_GAP;
                        case (state)
                            S_ACCUM: state <= S_MEAN;
                            S_COMP: state <= S_COMP_DRAIN;
                            S_CHROMA: state <= S_CHROMA_DRAIN;
                            default: state <= S_FINISH;
                        endcase
                    end
                end
                S_MEAN, S_COMP_DRAIN, S_CHROMA_DRAIN: begin
                    gap_cnt <= gap_cnt - 1'b1;
                    if (gap_cnt == '0) begin
                        case (state)
                            S_MEAN: state <= S_COMP;
                            S_COMP_DRAIN: state <= S_CHROMA;
                            default: state <= S_MEASURE;
                        endcase
                    end
                end
                S_FINISH: begin
                    // Counts settle on this edge
                    done  <= 1'b1;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Index 0 lines up with the read data, 1 and 2 follow it
    always_ff @(posedge clk) begin
        if (!rst) begin
            line_valid <= '0;
            phase      <= IDLE;
        end
        else begin
            line_valid <= {line_valid[1:0], issue};
            phase      <= state_phase;
        end
    end

    always_ff @(posedge clk) begin
        line_addr[0] <= rd_addr;
        line_addr[1] <= line_addr[0];
        line_addr[2] <= line_addr[1];
    end

    assign pass_first = line_valid[0] && (line_addr[0] == '0);
    assign pass_last  = line_valid[0] && (line_addr[0] == LAST_ADDR);

    // Tap depth is read latency plus the latency of the active unit
    always_comb begin
        case (phase)
            COMP: begin
                we      = line_valid[2];
                wr_addr = line_addr[2];
            end
            CHROMA: begin
                we      = line_valid[1];
                wr_addr = line_addr[1];
            end
            default: begin
                we      = 1'b0;
                wr_addr = line_addr[2];
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst)
        we |-> state inside {S_COMP, S_COMP_DRAIN, S_CHROMA, S_CHROMA_DRAIN})
        else $error("frame store write outside the writing passes");

endmodule

//--- rtl/hand_segment.sv
module hand_segment
    import pixel_pkg::*;
    import phase_pkg::*;
#(
    parameter int FRAME_W = 320,
    parameter int FRAME_H = 240,
    localparam int PIXELS = FRAME_W * FRAME_H,
    localparam int ADDR_W = $clog2(PIXELS + 1)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    output logic              done,
    output logic [ADDR_W-1:0] rd_addr,
    input  pixel_t            rd_red,
    input  pixel_t            rd_green,
    input  pixel_t            rd_blue,
    output logic              we,
    output logic [ADDR_W-1:0] wr_addr,
    output pixel_t            wr_red,
    output pixel_t            wr_green,
    output pixel_t            wr_blue,
    output logic [ADDR_W-1:0] area,
    output logic [ADDR_W-1:0] perimeter
);

    phase_t phase;
    logic   pass_first;
    logic   pass_last;
    pixel_t red_mean;
    pixel_t green_mean;
    pixel_t blue_mean;
    pixel_t max_mean;
    pixel_t comp_red;
    pixel_t comp_green;
    pixel_t comp_blue;
    pixel_t mask_pixel;

    frame_sequencer #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_sequencer (
        .clk(clk), .rst(rst), .start(start), .phase(phase),
        .pass_first(pass_first), .pass_last(pass_last), .rd_addr(rd_addr),
        .we(we), .wr_addr(wr_addr), .done(done)
    );

    channel_mean #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_mean (
        .clk(clk), .rst(rst), .phase(phase), .pass_first(pass_first),
        .pass_last(pass_last), .rd_red(rd_red), .rd_green(rd_green), .rd_blue(rd_blue),
        .red_mean(red_mean), .green_mean(green_mean), .blue_mean(blue_mean),
        .max_mean(max_mean)
    );

    illum_comp u_comp (
        .clk(clk), .rst(rst), .rd_red(rd_red), .rd_green(rd_green), .rd_blue(rd_blue),
        .red_mean(red_mean), .green_mean(green_mean), .blue_mean(blue_mean),
        .max_mean(max_mean), .comp_red(comp_red), .comp_green(comp_green),
        .comp_blue(comp_blue)
    );

    skin_classify u_skin (
        .clk(clk), .rst(rst), .rd_red(rd_red), .rd_green(rd_green), .rd_blue(rd_blue),
        .mask_pixel(mask_pixel)
    );

    blob_measure #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_measure (
        .clk(clk), .rst(rst), .phase(phase), .pass_first(pass_first), .rd_red(rd_red),
        .area(area), .perimeter(perimeter)
    );

    // Mask pass writes the same value on every channel
    assign wr_red   = (phase == COMP) ? comp_red : mask_pixel;
    assign wr_green = (phase == COMP) ? comp_green : mask_pixel;
    assign wr_blue  = (phase == COMP) ? comp_blue : mask_pixel;

endmodule

//--- tb/hand_model.svh
`ifndef HAND_MODEL_SVH
`define HAND_MODEL_SVH

// Channel mean over the frame, truncated
function automatic pixel_t truncated_mean(input longint sum, input int count);
    return pixel_t'(sum / count);
endfunction

function automatic pixel_t largest_of(input pixel_t a, input pixel_t b, input pixel_t c);
    pixel_t top;
    top = (a > b) ? a : b;
    return (top > c) ? top : c;
endfunction

// Channel times its mean over the largest mean, zero for a black frame
function automatic pixel_t compensate(input pixel_t ch, input pixel_t mean, input pixel_t top);
    if (top == 8'd0) begin
        return 8'd0;
    end
    return pixel_t'((int'(ch) * int'(mean)) / int'(top));
endfunction

// Integer divide truncates toward zero, so negative remainders step down once
function automatic int floor_div256(input int num);
    int q;
    q = num / 256;
    if (num < 0 && q * 256 != num) begin
        q = q - 1;
    end
    return q;
endfunction

function automatic pixel_t skin_mask(input pixel_t r, input pixel_t g, input pixel_t b);
    int cb;
    int cr;
    cb = CHROMA_OFFSET + floor_div256(CB_B * int'(b) - CB_R * int'(r) - CB_G * int'(g));
    cr = CHROMA_OFFSET + floor_div256(CR_R * int'(r) - CR_G * int'(g) - CR_B * int'(b));
    if (cb >= CB_MIN && cb <= CB_MAX && cr >= CR_MIN && cr <= CR_MAX) begin
        return MASK_ON;
    end
    return MASK_OFF;
endfunction

// One perimeter step for each change of value along the address walk
function automatic int edge_step(input pixel_t cur, input pixel_t prev);
    return (cur != prev) ? 1 : 0;
endfunction

`endif

//--- tb/tb_hand_segment.sv
module tb_hand_segment
    import pixel_pkg::*;
();

    localparam int FRAME_W = 16;
    localparam int FRAME_H = 8;
    localparam int PIXELS = FRAME_W * FRAME_H;
    localparam int ADDR_W = $clog2(PIXELS + 1);
    localparam int RUNS = 3;
    localparam int TIMEOUT_CYCLES = RUNS * (4 * PIXELS + 32) * 2;

    `include "hand_model.svh"

    logic              clk;
    logic              rst;
    logic              start;
    logic              done;
    logic [ADDR_W-1:0] rd_addr;
    pixel_t            rd_red, rd_green, rd_blue;
    logic              we;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_red, wr_green, wr_blue;
    logic [ADDR_W-1:0] area;
    logic [ADDR_W-1:0] perimeter;

    pixel_t mem_red [PIXELS], mem_green [PIXELS], mem_blue [PIXELS];
    pixel_t frame_red [PIXELS], frame_green [PIXELS], frame_blue [PIXELS];
    pixel_t exp_red [PIXELS], exp_green [PIXELS], exp_blue [PIXELS];
    pixel_t exp_mask [PIXELS];
    pixel_t exp_wr_red, exp_wr_green, exp_wr_blue;
    int     exp_area;
    int     exp_perim;
    logic   load_frame;
    logic   run_started;
    logic   saw_on;
    logic   saw_off;
    int     write_idx = 0;
    int     cycle_cnt = 0;
    int     mismatch_count = 0;
    int     fail_count = 0;

    hand_segment #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) DUT (
        .clk(clk), .rst(rst), .start(start), .done(done), .rd_addr(rd_addr),
        .rd_red(rd_red), .rd_green(rd_green), .rd_blue(rd_blue), .we(we),
        .wr_addr(wr_addr), .wr_red(wr_red), .wr_green(wr_green), .wr_blue(wr_blue),
        .area(area), .perimeter(perimeter)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Frame store with a one-cycle registered read, loaded between runs
    initial begin
        int fetch;
        rd_red = '0;
        rd_green = '0;
        rd_blue = '0;
        forever begin
            @(posedge clk);
            fetch = int'(rd_addr) % PIXELS;
            if (load_frame) begin
                for (int i = 0; i < PIXELS; i++) begin
                    mem_red[i] = frame_red[i];
                    mem_green[i] = frame_green[i];
                    mem_blue[i] = frame_blue[i];
                end
            end
            if (we) begin
                mem_red[wr_addr] = wr_red;
                mem_green[wr_addr] = wr_green;
                mem_blue[wr_addr] = wr_blue;
            end
            #1;
            rd_red = mem_red[fetch];
            rd_green = mem_green[fetch];
            rd_blue = mem_blue[fetch];
        end
    end

    task automatic report_counts();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("sim failed");
            $finish;
        end
    end

    // Writes of the current run, cleared once done is seen
    always @(posedge clk) begin
        if (done) begin
            write_idx <= 0;
        end
        else if (we) begin
            write_idx <= write_idx + 1;
        end
    end

    // First pass of writes carries compensated pixels, the second the mask
    always_comb begin
        if (write_idx < PIXELS) begin
            exp_wr_red = exp_red[write_idx % PIXELS];
            exp_wr_green = exp_green[write_idx % PIXELS];
            exp_wr_blue = exp_blue[write_idx % PIXELS];
        end
        else begin
            exp_wr_red = exp_mask[write_idx % PIXELS];
            exp_wr_green = exp_mask[write_idx % PIXELS];
            exp_wr_blue = exp_mask[write_idx % PIXELS];
        end
    end

    assert property (@(posedge clk) (cycle_cnt != 0 && !run_started) |->
        (!we && !done && area == '0 && perimeter == '0))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: outputs active before the first run", $time);
        end

    assert property (@(posedge clk) disable iff (!rst)
        we |-> (wr_addr == ADDR_W'(write_idx % PIXELS)) && (write_idx < 2 * PIXELS))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: write %0d went to address %0d", $time,
                $sampled(write_idx), $sampled(wr_addr));
        end

    assert property (@(posedge clk) disable iff (!rst)
        we |-> (wr_red == exp_wr_red) && (wr_green == exp_wr_green) && (wr_blue == exp_wr_blue))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: write %0d data %h %h %h, expected %h %h %h", $time,
                $sampled(write_idx), $sampled(wr_red), $sampled(wr_green), $sampled(wr_blue),
                $sampled(exp_wr_red), $sampled(exp_wr_green), $sampled(exp_wr_blue));
        end

    assert property (@(posedge clk) disable iff (!rst)
        $rose(done) |-> (write_idx == 2 * PIXELS) && (area == ADDR_W'(exp_area)) &&
            (perimeter == ADDR_W'(exp_perim)))
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: area %0d perimeter %0d after %0d writes, expected %0d %0d",
                $time, $sampled(area), $sampled(perimeter), $sampled(write_idx), exp_area,
                exp_perim);
        end

    assert property (@(posedge clk) disable iff (!rst) done |-> !we)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: frame store written while done is high", $time);
        end

    assert property (@(posedge clk) disable iff (!rst) (done && start) |=> done)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: done fell while start was still high", $time);
        end

    assert property (@(posedge clk) disable iff (!rst) (done && !start) |=> !done)
        else begin
            mismatch_count++;
            $display("MISMATCH at %0t: done stayed high after start went low", $time);
        end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // New frame plus the expected compensation, mask and counts
    task automatic prepare_frame(input bit blank);
        longint sum_red, sum_green, sum_blue;
        pixel_t mean_red, mean_green, mean_blue;
        pixel_t top;
        pixel_t prev;
        sum_red = 0;
        sum_green = 0;
        sum_blue = 0;
        for (int i = 0; i < PIXELS; i++) begin
            if (blank) begin
                frame_red[i] = '0;
                frame_green[i] = '0;
                frame_blue[i] = '0;
            end
            else if ($urandom % 2 == 0) begin
                // Warm skin tone, red over green over blue
                frame_red[i] = pixel_t'(170 + $urandom % 40);
                frame_green[i] = pixel_t'(115 + $urandom % 40);
                frame_blue[i] = pixel_t'(95 + $urandom % 40);
            end
            else begin
                frame_red[i] = pixel_t'($urandom);
                frame_green[i] = pixel_t'($urandom);
                frame_blue[i] = pixel_t'($urandom);
            end
            sum_red += frame_red[i];
            sum_green += frame_green[i];
            sum_blue += frame_blue[i];
        end
        mean_red = truncated_mean(sum_red, PIXELS);
        mean_green = truncated_mean(sum_green, PIXELS);
        mean_blue = truncated_mean(sum_blue, PIXELS);
        top = largest_of(mean_red, mean_green, mean_blue);
        exp_area = 0;
        exp_perim = 0;
        prev = 8'd0;
        for (int i = 0; i < PIXELS; i++) begin
            exp_red[i] = compensate(frame_red[i], mean_red, top);
            exp_green[i] = compensate(frame_green[i], mean_green, top);
            exp_blue[i] = compensate(frame_blue[i], mean_blue, top);
            exp_mask[i] = skin_mask(exp_red[i], exp_green[i], exp_blue[i]);
            saw_on |= (exp_mask[i] == MASK_ON);
            saw_off |= (exp_mask[i] == MASK_OFF);
            exp_area += (exp_mask[i] == MASK_ON) ? 1 : 0;
            exp_perim += edge_step(exp_mask[i], prev);
            prev = exp_mask[i];
        end
    endtask

    task automatic run_frame(input bit blank);
        prepare_frame(blank);
        load_frame = 1'b1;
        step();
        load_frame = 1'b0;
        run_started = 1'b1;
        start = 1'b1;
        while (!done) begin
            step();
        end
        // Start held high a while, done has to stay up
        repeat (4) step();
        start = 1'b0;
        while (done) begin
            step();
        end
    endtask

    initial begin
        void'($urandom(32'h3cb8));
        rst = 1'b0;
        start = 1'b0;
        load_frame = 1'b0;
        run_started = 1'b0;
        saw_on = 1'b0;
        saw_off = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (5) step();
        run_frame(1'b0);
        run_frame(1'b0);
        run_frame(1'b1);
        step();
        if (!(saw_on && saw_off)) begin
            fail_count++;
            $display("Coverage failure: the mask frames never held both skin and background");
        end
        report_counts();
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("sim passed");
        end
        else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- hand_segment.f
+incdir+tb
rtl/pixel_pkg.sv
rtl/phase_pkg.sv
rtl/channel_mean.sv
rtl/illum_comp.sv
rtl/skin_classify.sv
rtl/blob_measure.sv
rtl/frame_sequencer.sv
rtl/hand_segment.sv
tb/tb_hand_segment.sv

//--- Makefile
TOP = tb_hand_segment

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f hand_segment.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
